/* Bender.yml */
package:
  name: blocking_cache

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_pkg.sv
      - hw/cache_req_decode.sv
      - hw/cache_ctrl.sv
      - hw/cache_tag_data_exec.sv
      - hw/cache_resp_result.sv
      - hw/blocking_cache_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tests/cache_tb.sv

/* hw/blocking_cache_top.sv */
// Blocking data cache
// Direct-mapped, write-back, write-allocate; one word access at a time

`timescale 1ns/10ps

`include "cache_settings.svh"

module blocking_cache_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cachereq_val,
  input  cache_pkg::cache_req_t  cachereq_msg,
  output logic                   busy,
  output logic                   cacheresp_val,
  output cache_pkg::cache_resp_t cacheresp_msg,
  output logic                   memreq_val,
  output cache_pkg::mem_req_t    memreq_msg,
  input  logic                   memresp_val,
  input  cache_pkg::mem_resp_t   memresp_msg
);

  cache_pkg::cache_op_e     op;
  cache_pkg::addr_fields_t  fields;
  cache_pkg::mem_op_e       memreq_op;
  logic [`CACHE_WORD_W-1:0] wdata;
  logic [`CACHE_LINE_W-1:0] line;
  logic [`CACHE_TAG_W-1:0]  victim_tag;
  logic                     capture;
  logic                     hit;
  logic                     victim_dirty;
  logic                     array_wen;
  logic                     refill_sel;
  logic                     set_dirty;
  logic                     memreq_sel_wb;

  // Decode
  cache_req_decode decode_i (
    .clk    (clk),
    .arst_n (arst_n),
    .capture(capture),
    .req    (cachereq_msg),
    .op     (op),
    .wdata  (wdata),
    .fields (fields)
  );

  cache_ctrl ctrl_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cachereq_val (cachereq_val),
    .op           (op),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .memresp_val  (memresp_val),
    .capture      (capture),
    .busy         (busy),
    .array_wen    (array_wen),
    .refill_sel   (refill_sel),
    .set_dirty    (set_dirty),
    .memreq_sel_wb(memreq_sel_wb),
    .memreq_val   (memreq_val),
    .memreq_op    (memreq_op),
    .cacheresp_val(cacheresp_val)
  );

  // Execute
  cache_tag_data_exec exec_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .fields      (fields),
    .op          (op),
    .wdata       (wdata),
    .array_wen   (array_wen),
    .refill_sel  (refill_sel),
    .set_dirty   (set_dirty),
    .refill_line (memresp_msg.data),
    .hit         (hit),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag),
    .line        (line)
  );

  // Result
  cache_resp_result result_i (
    .op           (op),
    .fields       (fields),
    .line         (line),
    .victim_tag   (victim_tag),
    .memreq_sel_wb(memreq_sel_wb),
    .memreq_op    (memreq_op),
    .resp         (cacheresp_msg),
    .mreq         (memreq_msg)
  );

endmodule

/* hw/cache_ctrl.sv */
// Cache controller
// FSM that steps through tag check, write-back, refill and response

`timescale 1ns/10ps

module cache_ctrl (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cachereq_val,
  input  cache_pkg::cache_op_e op,
  input  logic                 hit,
  input  logic                 victim_dirty,
  input  logic                 memresp_val,
  output logic                 capture,
  output logic                 busy,
  output logic                 array_wen,
  output logic                 refill_sel,
  output logic                 set_dirty,
  output logic                 memreq_sel_wb,
  output logic                 memreq_val,
  output cache_pkg::mem_op_e   memreq_op,
  output logic                 cacheresp_val
);

  cache_pkg::cache_state_e state_q;
  cache_pkg::cache_state_e state_d;
  logic                    is_write;

  assign is_write = (op == cache_pkg::OP_WRITE);

  // ------------------------------
  // State register
  // ------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= cache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      // A new request may arrive in the response cycle
      cache_pkg::IDLE,
      cache_pkg::RESPOND: begin
        if (cachereq_val) begin
          state_d = cache_pkg::TAG_CHECK;
        end else begin
          state_d = cache_pkg::IDLE;
        end
      end
      cache_pkg::TAG_CHECK: begin
        if (hit) begin
          state_d = cache_pkg::RESPOND;
        end else if (victim_dirty) begin
          state_d = cache_pkg::WRITEBACK;
        end else begin
          state_d = cache_pkg::REFILL_REQ;
        end
      end
      cache_pkg::WRITEBACK:   state_d = cache_pkg::REFILL_REQ;
      cache_pkg::REFILL_REQ:  state_d = cache_pkg::REFILL_WAIT;
      cache_pkg::REFILL_WAIT: begin
        if (memresp_val) begin
          state_d = cache_pkg::WRITE_LINE;
        end
      end
      cache_pkg::WRITE_LINE:  state_d = cache_pkg::RESPOND;
      default:                state_d = cache_pkg::IDLE;
    endcase
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  // Busy drops together with the response pulse
  assign busy    = !(state_q inside {cache_pkg::IDLE, cache_pkg::RESPOND});
  assign capture = cachereq_val && !busy;

  // Array write on a write hit or when the refilled line lands
  assign array_wen  = ((state_q == cache_pkg::TAG_CHECK) && hit && is_write) ||
                      (state_q == cache_pkg::WRITE_LINE);
  assign refill_sel = (state_q == cache_pkg::WRITE_LINE);
  assign set_dirty  = is_write;

  assign memreq_sel_wb = (state_q == cache_pkg::WRITEBACK);
  assign memreq_val    = (state_q == cache_pkg::WRITEBACK) ||
                         (state_q == cache_pkg::REFILL_REQ);
  assign memreq_op     = memreq_sel_wb ? cache_pkg::MEM_WRITE : cache_pkg::MEM_READ;

  assign cacheresp_val = (state_q == cache_pkg::RESPOND);

  // ------------------------------
  // Protocol checks
  // ------------------------------

  a_no_req_when_busy : assert property (
    @(posedge clk) disable iff (!arst_n)
    cachereq_val |-> !busy
  );

  a_resp_only_waiting : assert property (
    @(posedge clk) disable iff (!arst_n)
    memresp_val |-> (state_q == cache_pkg::REFILL_WAIT)
  );

endmodule

/* hw/cache_pkg.sv */
// Blocking cache types
// Request, response and memory messages plus the opcode and state enums

`include "cache_settings.svh"

package cache_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    IDLE,
    TAG_CHECK,
    WRITEBACK,
    REFILL_REQ,
    REFILL_WAIT,
    WRITE_LINE,
    RESPOND
  } cache_state_e;

  // Processor side, 65 and 33 bits
  typedef struct packed {
    cache_op_e                op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_WORD_W-1:0] data;
  } cache_req_t;

  typedef struct packed {
    cache_op_e                op;
    logic [`CACHE_WORD_W-1:0] data;
  } cache_resp_t;

  // Memory side moves whole lines
  typedef struct packed {
    mem_op_e                  op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_LINE_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [`CACHE_LINE_W-1:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [1:0]              off;
  } addr_fields_t;

endpackage

/* hw/cache_req_decode.sv */
// Cache request decode
// Holds the accepted request and splits its address into tag, index and word offset

`timescale 1ns/10ps

`include "cache_settings.svh"

module cache_req_decode (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       capture,
  input  cache_pkg::cache_req_t      req,
  output cache_pkg::cache_op_e       op,
  output logic [`CACHE_WORD_W-1:0]   wdata,
  output cache_pkg::addr_fields_t    fields
);

  cache_pkg::cache_req_t req_q;

  // Request register, loaded only when the controller accepts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= '0;
    end else if (capture) begin
      req_q <= req;
    end
  end

  assign op    = req_q.op;
  assign wdata = req_q.data;

  // Address split
  assign fields.tag = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign fields.idx = req_q.addr[`CACHE_ADDR_W-`CACHE_TAG_W-1 -: `CACHE_IDX_W];
  assign fields.off = req_q.addr[3:2];

  // ------------------------------
  // Checks
  // ------------------------------

  // Only word accesses are served
  a_word_aligned : assert property (
    @(posedge clk) disable iff (!arst_n)
    capture |=> (req_q.addr[1:0] == 2'b00)
  );

endmodule

/* hw/cache_resp_result.sv */
// Cache result stage
// Picks the requested word and packs the cache response and memory request

`timescale 1ns/10ps

`include "cache_settings.svh"

module cache_resp_result (
  input  cache_pkg::cache_op_e      op,
  input  cache_pkg::addr_fields_t   fields,
  input  logic [`CACHE_LINE_W-1:0]  line,
  input  logic [`CACHE_TAG_W-1:0]   victim_tag,
  input  logic                      memreq_sel_wb,
  input  cache_pkg::mem_op_e        memreq_op,
  output cache_pkg::cache_resp_t    resp,
  output cache_pkg::mem_req_t       mreq
);

  localparam int unsigned LINE_OFF_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_IDX_W;

  logic [`CACHE_WORD_W-1:0] sel_word;
  logic [`CACHE_TAG_W-1:0]  mem_tag;

  // ------------------------------
  // Cache response
  // ------------------------------

  assign sel_word = line[fields.off*`CACHE_WORD_W +: `CACHE_WORD_W];

  assign resp.op   = op;
  // Writes return zero data
  assign resp.data = (op == cache_pkg::OP_READ) ? sel_word : '0;

  // ------------------------------
  // Memory request
  // ------------------------------

  // Old line address for write-back, requested line for refill
  assign mem_tag = memreq_sel_wb ? victim_tag : fields.tag;

  assign mreq.op   = memreq_op;
  assign mreq.addr = {mem_tag, fields.idx, {LINE_OFF_W{1'b0}}};
  assign mreq.data = line;

endmodule

/* hw/cache_settings.svh */
// Blocking cache settings
// Fixed geometry of the direct-mapped cache: 16 lines of 16 bytes

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Byte address width
`define CACHE_ADDR_W 32

// Processor word width
`define CACHE_WORD_W 32

// One cache line holds four words
`define CACHE_LINE_W 128

// Number of lines, 256 bytes in total
`define CACHE_NLINES 16

// Index selects one of the lines
`define CACHE_IDX_W 4

// Address bits 31 down to 8
`define CACHE_TAG_W 24

`endif

/* hw/cache_tag_data_exec.sv */
// Cache arrays
// Tag, valid, dirty and data storage with refill/write merge and the hit test

`timescale 1ns/10ps

`include "cache_settings.svh"

module cache_tag_data_exec (
  input  logic                      clk,
  input  logic                      arst_n,
  input  cache_pkg::addr_fields_t   fields,
  input  cache_pkg::cache_op_e      op,
  input  logic [`CACHE_WORD_W-1:0]  wdata,
  input  logic                      array_wen,
  input  logic                      refill_sel,
  input  logic                      set_dirty,
  input  logic [`CACHE_LINE_W-1:0]  refill_line,
  output logic                      hit,
  output logic                      victim_dirty,
  output logic [`CACHE_TAG_W-1:0]   victim_tag,
  output logic [`CACHE_LINE_W-1:0]  line
);

  logic [`CACHE_TAG_W-1:0]  tag_mem  [`CACHE_NLINES];
  logic [`CACHE_LINE_W-1:0] data_mem [`CACHE_NLINES];
  logic [`CACHE_NLINES-1:0] valid_q;
  logic [`CACHE_NLINES-1:0] dirty_q;
  logic [`CACHE_LINE_W-1:0] refill_buf;
  logic [`CACHE_LINE_W-1:0] wr_line;

  // ------------------------------
  // Lookup
  // ------------------------------

  assign victim_tag   = tag_mem[fields.idx];
  assign line         = data_mem[fields.idx];
  assign hit          = valid_q[fields.idx] && (victim_tag == fields.tag);
  assign victim_dirty = valid_q[fields.idx] && dirty_q[fields.idx];

  // Memory data is a one-cycle strobe.
  // The line is written in the cycle right after it, so a plain delay holds it.
  always_ff @(posedge clk) begin
    refill_buf <= refill_line;
  end

  // Line to store, with the addressed word replaced on writes
  always_comb begin
    wr_line = refill_sel ? refill_buf : line;
    if (op == cache_pkg::OP_WRITE) begin
      wr_line[fields.off*`CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
    end
  end

  // ------------------------------
  // Array update
  // ------------------------------

  always_ff @(posedge clk) begin
    if (array_wen) begin
      tag_mem[fields.idx]  <= fields.tag;
      data_mem[fields.idx] <= wr_line;
    end
  end

  // Valid on any write, dirty only after a write op
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (array_wen) begin
      valid_q[fields.idx] <= 1'b1;
      dirty_q[fields.idx] <= set_dirty;
    end
  end

endmodule

/* tb.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_req_decode.sv
hw/cache_ctrl.sv
hw/cache_tag_data_exec.sv
hw/cache_resp_result.sv
hw/blocking_cache_top.sv
tests/cache_tb.sv

/* tests/cache_tb.sv */
// Blocking cache testbench
// Replays the access list against a line memory model and checks every response

`timescale 1ns/10ps

`include "cache_settings.svh"

module cache_tb;

  logic                   clk;
  logic                   arst_n;
  logic                   cachereq_val;
  cache_pkg::cache_req_t  cachereq_msg;
  logic                   busy;
  logic                   cacheresp_val;
  cache_pkg::cache_resp_t cacheresp_msg;
  logic                   memreq_val;
  cache_pkg::mem_req_t    memreq_msg;
  logic                   memresp_val;
  cache_pkg::mem_resp_t   memresp_msg;

  // Backing memory and the memory image the program expects to see
  logic [31:0] mem    [logic [31:0]];
  logic [31:0] golden [logic [31:0]];

  // Line held at each index, as implied by the accesses so far
  logic [31:0]              cached_line [`CACHE_NLINES];
  logic [`CACHE_NLINES-1:0] cached_valid;

  // Access list
  logic [31:0] vec_op    [$];
  logic [31:0] vec_addr  [$];
  logic [31:0] vec_wdata [$];
  logic [31:0] vec_rdata [$];
  int unsigned vec_reqs  [$];

  int unsigned err_cnt;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned resp_wait;
  logic [31:0] resp_addr;

  blocking_cache_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cachereq_val (cachereq_val),
    .cachereq_msg (cachereq_msg),
    .busy         (busy),
    .cacheresp_val(cacheresp_val),
    .cacheresp_msg(cacheresp_msg),
    .memreq_val   (memreq_val),
    .memreq_msg   (memreq_msg),
    .memresp_val  (memresp_val),
    .memresp_msg  (memresp_msg)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Memory model
  // ------------------------------

  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return init_word(addr);
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (golden.exists(addr)) begin
      return golden[addr];
    end
    return init_word(addr);
  endfunction

  task automatic show_mismatch(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    $display("Fail %s: got %0h, expected %0h", name, got, exp);
    err_cnt++;
  endtask

  task automatic note_problem(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  // One clock of the memory side, called at each rising edge
  task automatic service_memory();
    logic [`CACHE_LINE_W-1:0] rd_line;
    int                       w;
    rd_line = '0;
    memresp_val <= 1'b0;
    if (resp_wait > 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        for (w = 0; w < 4; w++) begin
          rd_line[w*32 +: 32] = mem_word(resp_addr + 4 * w);
        end
        memresp_val      <= 1'b1;
        memresp_msg.data <= rd_line;
      end
    end
    if (memreq_val) begin
      if (memreq_msg.op == cache_pkg::MEM_WRITE) begin
        for (w = 0; w < 4; w++) begin
          mem[memreq_msg.addr + 4 * w] = memreq_msg.data[w*32 +: 32];
        end
      end else begin
        resp_addr = memreq_msg.addr;
        resp_wait = ($urandom % 4) + 1;
      end
    end
  endtask

  // ------------------------------
  // Accesses
  // ------------------------------

  task automatic run_access(input logic [31:0] op_code, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_data,
                            input int unsigned exp_reqs);
    cache_pkg::cache_op_e    op;
    logic [31:0]             line_addr;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [31:0]             victim_addr;
    int unsigned             lat;
    int unsigned             reqs;
    bit                      seen_read;
    bit                      done;
    int                      w;
    op          = cache_pkg::cache_op_e'(op_code[0]);
    line_addr   = {addr[31:4], 4'h0};
    idx         = addr[7:4];
    victim_addr = cached_line[idx];
    lat         = 0;
    reqs        = 0;
    seen_read   = 1'b0;
    done        = 1'b0;
    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
    cachereq_val      <= 1'b1;
    cachereq_msg.op   <= op;
    cachereq_msg.addr <= addr;
    cachereq_msg.data <= wdata;
    while (!done) begin
      @(posedge clk);
      lat++;
      cachereq_val <= 1'b0;
      if (memreq_val) begin
        reqs++;
        if (memreq_msg.op == cache_pkg::MEM_READ) begin
          if (seen_read) begin
            note_problem("a second refill read was issued for one access");
          end
          if (memreq_msg.addr !== line_addr) begin
            show_mismatch("memreq_msg.addr", memreq_msg.addr, line_addr);
          end
          seen_read = 1'b1;
        end else begin
          if (seen_read) begin
            note_problem("the write-back came after the refill read");
          end
          if (!cached_valid[idx]) begin
            note_problem("a write-back was issued for a line that holds nothing");
          end else begin
            if (memreq_msg.addr !== victim_addr) begin
              show_mismatch("memreq_msg.addr", memreq_msg.addr, victim_addr);
            end
            for (w = 0; w < 4; w++) begin
              if (memreq_msg.data[w*32 +: 32] !== expected_word(victim_addr + 4 * w)) begin
                show_mismatch("memreq_msg.data", memreq_msg.data[w*32 +: 32],
                              expected_word(victim_addr + 4 * w));
              end
            end
          end
        end
      end
      service_memory();
      if (cacheresp_val) begin
        done = 1'b1;
        // Busy drops together with the response
        if (busy !== 1'b0) begin
          show_mismatch("busy", busy, 0);
        end
      end else if (lat >= 2 && !busy) begin
        note_problem("busy went low before the response");
      end
    end
    if (reqs != exp_reqs) begin
      show_mismatch("memreq_val count", reqs, exp_reqs);
    end
    if (exp_reqs > 0 && !seen_read) begin
      note_problem("the miss issued no refill read");
    end
    if (cacheresp_msg.op !== op) begin
      show_mismatch("cacheresp_msg.op", cacheresp_msg.op, op);
    end
    if (cacheresp_msg.data !== exp_data) begin
      show_mismatch("cacheresp_msg.data", cacheresp_msg.data, exp_data);
    end
    // Hits answer three edges after the strobe was driven
    if (exp_reqs == 0 && lat != 3) begin
      show_mismatch("cacheresp_val latency", lat, 3);
    end
    if (op == cache_pkg::OP_WRITE) begin
      golden[addr] = wdata;
    end
    cached_line[idx]  = line_addr;
    cached_valid[idx] = 1'b1;
  endtask

  // Dirty lines are lost, so only the backing memory survives
  task automatic reset_mid_run();
    arst_n      <= 1'b0;
    memresp_val <= 1'b0;
    resp_wait    = 0;
    cached_valid = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    if (busy !== 1'b0) begin
      show_mismatch("busy", busy, 0);
    end
    if (cacheresp_val !== 1'b0) begin
      show_mismatch("cacheresp_val", cacheresp_val, 0);
    end
    if (memreq_val !== 1'b0) begin
      show_mismatch("memreq_val", memreq_val, 0);
    end
    golden.delete();
    foreach (mem[a]) begin
      golden[a] = mem[a];
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    int          fd;
    int          n;
    int unsigned i;
    string       text;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_rdata;
    int unsigned f_reqs;
    clk          = 1'b0;
    arst_n       = 1'b0;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    memresp_val  = 1'b0;
    memresp_msg  = '0;
    err_cnt      = 0;
    resp_wait    = 0;
    resp_addr    = '0;
    cycle_limit  = 0;
    cached_valid = '0;
    void'($urandom(70));
    fd = $fopen("tests/cache_testdata.txt", "r");
    if (fd == 0) begin
      note_problem("the test data file tests/cache_testdata.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        text = "";
        if ($fgets(text, fd) != 0) begin
          if (text.len() > 1 && text.substr(0, 1) != "//") begin
            n = $sscanf(text, "%h %h %h %h %d", f_op, f_addr, f_wdata, f_rdata, f_reqs);
            if (n == 5) begin
              vec_op.push_back(f_op);
              vec_addr.push_back(f_addr);
              vec_wdata.push_back(f_wdata);
              vec_rdata.push_back(f_rdata);
              vec_reqs.push_back(f_reqs);
            end
          end
        end
      end
      $fclose(fd);
    end
    if (vec_op.size() == 0) begin
      note_problem("no accesses were read from the test data file");
    end
    cycle_limit = 40 * ((vec_op.size() > 0) ? vec_op.size() : 1);

    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    for (i = 0; i < vec_op.size(); i++) begin
      if (vec_op[i] == 32'h2) begin
        reset_mid_run();
      end else begin
        run_access(vec_op[i], vec_addr[i], vec_wdata[i], vec_rdata[i], vec_reqs[i]);
      end
    end
    @(posedge clk);
    $display("Ran %0d test lines, %0d errors", vec_op.size(), err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    err_cnt++;
    $display("Ran into the cycle limit, %0d errors", err_cnt);
    $display("Errors found");
    $finish;
  end

endmodule

/* tests/cache_testdata.txt */
// op (0 read, 1 write, 2 reset)  address  write data  expected read data  memory requests
// all fields hex except the memory request count, which is decimal
0 00000100 00000000 a5a50100 1
0 00000104 00000000 a5a50104 0
1 00000108 deadbeef 00000000 0
0 00000108 00000000 deadbeef 0
1 00000214 12345678 00000000 1
0 00000210 00000000 a5a50210 0
0 0000021c 00000000 a5a5021c 0
0 00000214 00000000 12345678 0
0 00000300 00000000 a5a50300 2
0 00000108 00000000 deadbeef 1
0 00000100 00000000 a5a50100 0
1 00001314 cafef00d 00000000 2
0 00000214 00000000 12345678 2
0 00001314 00000000 cafef00d 1
1 000004f0 0badcafe 00000000 1
0 000004f0 00000000 0badcafe 0
2 00000000 00000000 00000000 0
0 00000100 00000000 a5a50100 1
0 000004f0 00000000 a5a504f0 1
1 000000fc 55aa55aa 00000000 1
0 000000fc 00000000 55aa55aa 0
0 000000f0 00000000 a5a500f0 0
